// File: include/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

`define CORE_XLEN         32
`define CORE_REG_AW       5
`define CORE_REG_COUNT    32
`define CORE_SHAMT_W      5
`define CORE_WB_AW        6
`define CORE_INST_ADDR    6'd0
`define CORE_ILLEGAL_ADDR 6'd32

// Opcodes in bits 31:26
`define CORE_OP_SPECIAL   6'h00
`define CORE_OP_ADDI      6'h08
`define CORE_OP_ADDIU     6'h09
`define CORE_OP_SLTI      6'h0a
`define CORE_OP_SLTIU     6'h0b
`define CORE_OP_ANDI      6'h0c
`define CORE_OP_ORI       6'h0d
`define CORE_OP_XORI      6'h0e
`define CORE_OP_LUI       6'h0f

// SPECIAL funct codes in bits 5:0
`define CORE_FN_SLL       6'h00
`define CORE_FN_SRL       6'h02
`define CORE_FN_SRA       6'h03
`define CORE_FN_SLLV      6'h04
`define CORE_FN_SRLV      6'h06
`define CORE_FN_SRAV      6'h07
`define CORE_FN_ADD       6'h20
`define CORE_FN_ADDU      6'h21
`define CORE_FN_SUB       6'h22
`define CORE_FN_SUBU      6'h23
`define CORE_FN_AND       6'h24
`define CORE_FN_OR        6'h25
`define CORE_FN_XOR       6'h26
`define CORE_FN_NOR       6'h27
`define CORE_FN_SLT       6'h2a
`define CORE_FN_SLTU      6'h2b

`endif

// File: logic/corePkg.sv
package corePkg;

    // Operation carried by the micro-op into execute
    typedef enum logic [3:0] {
        AluAdd  = 4'd0,
        AluSub  = 4'd1,
        AluSlt  = 4'd2,
        AluSltu = 4'd3,
        AluAnd  = 4'd4,
        AluOr   = 4'd5,
        AluXor  = 4'd6,
        AluNor  = 4'd7,
        AluLui  = 4'd8,
        AluSll  = 4'd9,
        AluSrl  = 4'd10,
        AluSra  = 4'd11
    } aluOpE;

    // Second operand comes from a register or from the formed immediate
    typedef enum logic {
        SrcReg = 1'b0,
        SrcImm = 1'b1
    } op1SrcE;

endpackage

// File: logic/instDecode.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module instDecode
    import corePkg::*;
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       issue,
    input  logic [`CORE_XLEN-1:0]      inst,
    input  logic                       execValid,
    input  logic [`CORE_REG_AW-1:0]    execDst,
    input  logic [`CORE_XLEN-1:0]      execData,
    input  logic                       resValid,
    input  logic [`CORE_REG_AW-1:0]    resDst,
    input  logic [`CORE_XLEN-1:0]      resData,
    input  logic [`CORE_XLEN-1:0]      rfData0,
    input  logic [`CORE_XLEN-1:0]      rfData1,
    output logic [`CORE_REG_AW-1:0]    rfAddr0,
    output logic [`CORE_REG_AW-1:0]    rfAddr1,
    output logic                       decValid,
    output aluOpE                      decOp,
    output op1SrcE                     decSrc,
    output logic [`CORE_XLEN-1:0]      decA,
    output logic [`CORE_XLEN-1:0]      decB,
    output logic [`CORE_XLEN-1:0]      decImm,
    output logic [`CORE_SHAMT_W-1:0]   decShamt,
    output logic [`CORE_REG_AW-1:0]    decDst,
    output logic                       illegal
);
    logic [5:0]                 opcode;
    logic [5:0]                 funct;
    logic [`CORE_REG_AW-1:0]    rs;
    logic [`CORE_REG_AW-1:0]    rt;
    logic [`CORE_REG_AW-1:0]    rd;
    logic [`CORE_XLEN-1:0]      immSe;
    logic [`CORE_XLEN-1:0]      immZe;
    logic [`CORE_XLEN-1:0]      immSa;
    logic [`CORE_XLEN-1:0]      immLui;
    logic [`CORE_XLEN-1:0]      imm;
    logic [`CORE_XLEN-1:0]      opA;
    logic [`CORE_XLEN-1:0]      opB;
    logic [`CORE_REG_AW-1:0]    dst;
    logic                       legal;
    aluOpE                      op;
    op1SrcE                     src;

    assign opcode = inst[31:26];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign funct  = inst[5:0];
    assign immSe  = {{16{inst[15]}}, inst[15:0]};
    assign immZe  = {16'h0000, inst[15:0]};
    assign immSa  = {27'd0, inst[10:6]};
    assign immLui = {inst[15:0], 16'h0000};

    always_comb begin
        legal   = 1'b1;
        op      = AluAdd;
        src     = SrcImm;
        imm     = immSe;
        rfAddr0 = rs;
        rfAddr1 = rt;
        dst     = rt;
        if (opcode == `CORE_OP_SPECIAL) begin   // NOP is SLL to r0, so it becomes a bubble
            src = SrcReg;
            dst = rd;
            case (funct)
                `CORE_FN_ADD, `CORE_FN_ADDU: op = AluAdd;
                `CORE_FN_SUB, `CORE_FN_SUBU: op = AluSub;
                `CORE_FN_SLT:                op = AluSlt;
                `CORE_FN_SLTU:               op = AluSltu;
                `CORE_FN_AND:                op = AluAnd;
                `CORE_FN_OR:                 op = AluOr;
                `CORE_FN_XOR:                op = AluXor;
                `CORE_FN_NOR:                op = AluNor;
                `CORE_FN_SLL, `CORE_FN_SLLV: op = AluSll;
                `CORE_FN_SRL, `CORE_FN_SRLV: op = AluSrl;
                `CORE_FN_SRA, `CORE_FN_SRAV: op = AluSra;
                default:                     legal = 1'b0;
            endcase
            // Shifts take rt as the value and rs as the amount
            if (funct[5:3] == 3'b000) begin
                rfAddr0 = rt;
                rfAddr1 = rs;
                if (!funct[2]) begin    // Fixed amount from the shamt field
                    src = SrcImm;
                    imm = immSa;
                end
            end
        end else begin
            case (opcode)
                `CORE_OP_ADDI, `CORE_OP_ADDIU: op = AluAdd;
                `CORE_OP_SLTI:                 op = AluSlt;
                `CORE_OP_SLTIU:                op = AluSltu;
                `CORE_OP_ANDI:                 op = AluAnd;
                `CORE_OP_ORI:                  op = AluOr;
                `CORE_OP_XORI:                 op = AluXor;
                `CORE_OP_LUI:                  op = AluLui;
                default:                       legal = 1'b0;
            endcase
            if (op inside {AluAnd, AluOr, AluXor}) begin
                imm = immZe;
            end else if (op == AluLui) begin
                imm = immLui;
            end
        end
    end

    // Youngest result wins over the older one and the register file
    assign opA = (execValid && execDst == rfAddr0) ? execData :
                 (resValid && resDst == rfAddr0)   ? resData  : rfData0;
    assign opB = (execValid && execDst == rfAddr1) ? execData :
                 (resValid && resDst == rfAddr1)   ? resData  : rfData1;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            decValid <= issue && legal && (dst != '0);
            illegal  <= issue && !legal;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            decOp    <= op;
            decSrc   <= src;
            decA     <= opA;
            decB     <= opB;
            decImm   <= imm;
            decShamt <= imm[`CORE_SHAMT_W-1:0];
            decDst   <= dst;
        end
    end

    // The bus never issues on back-to-back cycles
    assert property (@(posedge clk) disable iff (!rstN) decValid |=> !decValid);

endmodule

// File: logic/aluExecute.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module aluExecute
    import corePkg::*;
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       decValid,
    input  aluOpE                      decOp,
    input  op1SrcE                     decSrc,
    input  logic [`CORE_XLEN-1:0]      decA,
    input  logic [`CORE_XLEN-1:0]      decB,
    input  logic [`CORE_XLEN-1:0]      decImm,
    input  logic [`CORE_SHAMT_W-1:0]   decShamt,
    input  logic [`CORE_REG_AW-1:0]    decDst,
    output logic                       execValid,
    output logic [`CORE_REG_AW-1:0]    execDst,
    output logic [`CORE_XLEN-1:0]      execData
);
    logic [`CORE_XLEN-1:0]      op1;
    logic [`CORE_SHAMT_W-1:0]   shamt;
    logic [`CORE_XLEN-1:0]      result;

    assign op1   = (decSrc == SrcImm) ? decImm : decB;
    assign shamt = (decSrc == SrcImm) ? decShamt : decB[`CORE_SHAMT_W-1:0];  // SLLV uses rs[4:0]

    always_comb begin
        case (decOp)
            AluAdd:  result = decA + op1;
            AluSub:  result = decA - op1;
            AluSlt:  result = {{(`CORE_XLEN-1){1'b0}}, $signed(decA) < $signed(op1)};
            AluSltu: result = {{(`CORE_XLEN-1){1'b0}}, decA < op1};
            AluAnd:  result = decA & op1;
            AluOr:   result = decA | op1;
            AluXor:  result = decA ^ op1;
            AluNor:  result = ~(decA | op1);
            AluLui:  result = op1;              // Immediate already shifted up
            AluSll:  result = decA << shamt;
            AluSrl:  result = decA >> shamt;
            AluSra:  result = $unsigned($signed(decA) >>> shamt);
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            execValid <= 1'b0;
        end else begin
            execValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        if (decValid) begin
            execDst  <= decDst;
            execData <= result;
        end
    end

    // Bypassed operands must never carry X into decode
    assert property (@(posedge clk) disable iff (!rstN) execValid |-> !$isunknown(execData));

endmodule

// File: logic/regResult.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module regResult (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       execValid,
    input  logic [`CORE_REG_AW-1:0]    execDst,
    input  logic [`CORE_XLEN-1:0]      execData,
    input  logic                       illegal,
    input  logic [`CORE_REG_AW-1:0]    rfAddr0,
    input  logic [`CORE_REG_AW-1:0]    rfAddr1,
    input  logic [`CORE_WB_AW-1:0]     readAddr,
    output logic                       resValid,
    output logic [`CORE_REG_AW-1:0]    resDst,
    output logic [`CORE_XLEN-1:0]      resData,
    output logic [`CORE_XLEN-1:0]      rfData0,
    output logic [`CORE_XLEN-1:0]      rfData1,
    output logic [`CORE_XLEN-1:0]      readData
);
    logic [`CORE_XLEN-1:0]  regs [`CORE_REG_COUNT];
    logic [`CORE_XLEN-1:0]  illegalCnt;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resValid <= 1'b0;
        end else begin
            resValid <= execValid;
        end
    end

    always_ff @(posedge clk) begin
        if (execValid) begin
            resDst  <= execDst;
            resData <= execData;
        end
    end

    // r0 stays zero since decode never lets a write to it through
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (resValid) begin
            regs[resDst] <= resData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            illegalCnt <= '0;
        end else if (illegal && illegalCnt != '1) begin
            illegalCnt <= illegalCnt + 1'b1;    // Saturates at all ones
        end
    end

    assign rfData0 = regs[rfAddr0];
    assign rfData1 = regs[rfAddr1];

    always_comb begin
        if (readAddr < `CORE_REG_COUNT) begin
            readData = regs[readAddr[`CORE_REG_AW-1:0]];
        end else if (readAddr == `CORE_ILLEGAL_ADDR) begin
            readData = illegalCnt;
        end else begin
            readData = '0;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) resValid |-> resDst != '0);

endmodule

// File: logic/wbAluCore.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module wbAluCore
    import corePkg::*;
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [`CORE_WB_AW-1:0]     adr,
    input  logic [`CORE_XLEN-1:0]      datIn,
    output logic [`CORE_XLEN-1:0]      datOut,
    output logic                       ack
);
    logic                       ackNext;
    logic                       issue;
    logic                       busy;
    logic [`CORE_REG_AW-1:0]    rfAddr0;
    logic [`CORE_REG_AW-1:0]    rfAddr1;
    logic [`CORE_XLEN-1:0]      rfData0;
    logic [`CORE_XLEN-1:0]      rfData1;
    logic                       decValid;
    aluOpE                      decOp;
    op1SrcE                     decSrc;
    logic [`CORE_XLEN-1:0]      decA;
    logic [`CORE_XLEN-1:0]      decB;
    logic [`CORE_XLEN-1:0]      decImm;
    logic [`CORE_SHAMT_W-1:0]   decShamt;
    logic [`CORE_REG_AW-1:0]    decDst;
    logic                       illegal;
    logic                       execValid;
    logic [`CORE_REG_AW-1:0]    execDst;
    logic [`CORE_XLEN-1:0]      execData;
    logic                       resValid;
    logic [`CORE_REG_AW-1:0]    resDst;
    logic [`CORE_XLEN-1:0]      resData;
    logic [`CORE_XLEN-1:0]      readData;

    assign busy = decValid | execValid | resValid;

    // Writes go straight through; reads wait for the pipeline to drain
    assign ackNext = cyc && stb && !ack && (we || !busy);
    assign issue   = ackNext && we && (adr == `CORE_INST_ADDR);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ack <= 1'b0;
        end else begin
            ack <= ackNext;
        end
    end

    assign datOut = (ack && !we) ? readData : '0;

    instDecode uDecode (
        .clk, .rstN, .issue, .inst(datIn),
        .execValid, .execDst, .execData,
        .resValid, .resDst, .resData,
        .rfData0, .rfData1, .rfAddr0, .rfAddr1,
        .decValid, .decOp, .decSrc, .decA, .decB, .decImm, .decShamt, .decDst,
        .illegal
    );

    aluExecute uExecute (
        .clk, .rstN,
        .decValid, .decOp, .decSrc, .decA, .decB, .decImm, .decShamt, .decDst,
        .execValid, .execDst, .execData
    );

    regResult uResult (
        .clk, .rstN,
        .execValid, .execDst, .execData, .illegal,
        .rfAddr0, .rfAddr1, .readAddr(adr),
        .resValid, .resDst, .resData, .rfData0, .rfData1, .readData
    );

endmodule

// File: sim/wbAluCore_tb.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module wbAluCore_tb;

    localparam int MaxRecords = 128;
    localparam int DepOps     = 24;

    logic                       clk;
    logic                       rstN;
    logic                       cyc;
    logic                       stb;
    logic                       we;
    logic [`CORE_WB_AW-1:0]     adr;
    logic [`CORE_XLEN-1:0]      datIn;
    logic [`CORE_XLEN-1:0]      datOut;
    logic                       ack;

    logic [31:0]    patMem [4*MaxRecords];     // Four words per record
    logic [31:0]    model [`CORE_REG_COUNT];
    logic [31:0]    rngState = 32'd87;
    int             recordCount = 0;
    int             cycleLimit = 0;
    int             testChecks = 0;
    int             testErrors = 0;
    int             totalChecks = 0;
    int             totalErrors = 0;

    wbAluCore dut (
        .clk, .rstN, .cyc, .stb, .we, .adr, .datIn, .datOut, .ack
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // Expected result from the MIPS32 definition of each operation
    function automatic logic [31:0] modelResult(input int sel, input logic [31:0] x,
                                                input logic [31:0] y);
        case (sel)
            0, 11:   return x + y;
            1:       return x - y;
            2:       return x & y;
            3:       return x | y;
            4, 12:   return x ^ y;
            5:       return ~(x | y);
            6:       return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            7:       return (x < y) ? 32'd1 : 32'd0;
            8:       return x << y[4:0];
            9:       return x >> y[4:0];
            default: return (x >> y[4:0]) | ({32{x[31]}} & ~(32'hffffffff >> y[4:0]));
        endcase
    endfunction

    // x is the register carrying the previous result, y the second source
    function automatic logic [31:0] encodeOp(input int sel, input logic [4:0] x,
                                             input logic [4:0] y, input logic [4:0] d,
                                             input logic [15:0] imm);
        logic [5:0]  fn;
        logic [31:0] word;
        case (sel)
            0:       fn = `CORE_FN_ADDU;
            1:       fn = `CORE_FN_SUBU;
            2:       fn = `CORE_FN_AND;
            3:       fn = `CORE_FN_OR;
            4:       fn = `CORE_FN_XOR;
            5:       fn = `CORE_FN_NOR;
            6:       fn = `CORE_FN_SLT;
            7:       fn = `CORE_FN_SLTU;
            8:       fn = `CORE_FN_SLLV;
            9:       fn = `CORE_FN_SRLV;
            default: fn = `CORE_FN_SRAV;
        endcase
        case (sel)
            11:       word = {`CORE_OP_ADDIU, x, d, imm};
            12:       word = {`CORE_OP_XORI, x, d, imm};
            8, 9, 10: word = {`CORE_OP_SPECIAL, y, x, d, 5'd0, fn};  // Value in rt
            default:  word = {`CORE_OP_SPECIAL, x, y, d, 5'd0, fn};
        endcase
        return word;
    endfunction

    function automatic string testName(input int num);
        case (num)
            1:       return "arithmetic and compare";
            2:       return "immediates and logic";
            3:       return "shifts";
            4:       return "dependent instructions";
            5:       return "r0 and illegal words";
            default: return "read after issue";
        endcase
    endfunction

    // Starts on a falling edge and returns on the falling edge that sees ack
    task automatic busWrite(input logic [`CORE_WB_AW-1:0] a, input logic [`CORE_XLEN-1:0] d);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        datIn = d;
        @(negedge clk);
        while (!ack) @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic busRead(input logic [`CORE_WB_AW-1:0] a, output logic [`CORE_XLEN-1:0] d);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        @(negedge clk);
        while (!ack) @(negedge clk);       // Held off while the pipeline drains
        d   = datOut;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic checkRead(input logic [`CORE_WB_AW-1:0] a, input logic [31:0] expVal);
        logic [31:0] got;
        busRead(a, got);
        testChecks++;
        totalChecks++;
        assert (got === expVal) else begin
            $display("FAILED at time %0t: address %0d read %h, expected %h", $time, a, got,
                     expVal);
            testErrors++;
            totalErrors++;
        end
    endtask

    task automatic reportTest(input int num);
        $display("Test %0d, %s: %0d checks, %0d errors", num, testName(num), testChecks,
                 testErrors);
        testChecks = 0;
        testErrors = 0;
    endtask

    task automatic loadRegister(input logic [4:0] r, input logic [31:0] v);
        busWrite(`CORE_INST_ADDR, {`CORE_OP_LUI, 5'd0, r, v[31:16]});
        busWrite(`CORE_INST_ADDR, {`CORE_OP_ORI, r, r, v[15:0]});
        model[r] = v;
    endtask

    task automatic replayPatterns();
        logic [31:0] kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expVal;
        int          i;
        for (i = 0; i < recordCount; i++) begin
            kind   = patMem[4*i];
            addr   = patMem[4*i+1];
            data   = patMem[4*i+2];
            expVal = patMem[4*i+3];
            case (kind)
                32'd1:   busWrite(addr[`CORE_WB_AW-1:0], data);
                32'd2:   checkRead(addr[`CORE_WB_AW-1:0], expVal);
                default: reportTest(int'(data));
            endcase
        end
    endtask

    // Dependent ops two or three cycles apart, so every operand comes through the bypass
    task automatic runDependencyTest();
        logic [31:0] rnd;
        logic [31:0] y;
        logic [15:0] imm;
        logic [4:0]  prevReg;
        logic [4:0]  srcReg;
        logic [4:0]  dstReg;
        logic [5:0]  idx;
        int          sel;
        for (idx = 0; idx < `CORE_REG_COUNT; idx++) begin
            model[idx[4:0]] = '0;
        end
        loadRegister(5'd26, nextRandom());
        loadRegister(5'd27, nextRandom());
        prevReg = 5'd26;
        repeat (DepOps) begin
            rnd    = nextRandom();
            sel    = int'(rnd % 13);
            srcReg = rnd[16] ? 5'd27 : 5'd26;
            dstReg = {3'b111, rnd[21:20]};      // r28 to r31
            imm    = rnd[31:16];
            case (sel)
                11:      y = {{16{imm[15]}}, imm};
                12:      y = {16'h0000, imm};
                default: y = model[srcReg];
            endcase
            if (rnd[25]) begin
                repeat (2) @(negedge clk);      // Previous result then sits in the result stage
            end
            busWrite(`CORE_INST_ADDR, encodeOp(sel, prevReg, srcReg, dstReg, imm));
            model[dstReg] = modelResult(sel, model[prevReg], y);
            prevReg = dstReg;
        end
        for (idx = 26; idx < `CORE_REG_COUNT; idx++) begin
            checkRead(idx, model[idx[4:0]]);
        end
    endtask

    task automatic runReadAfterIssue();
        logic [31:0] v;
        v = nextRandom();
        loadRegister(5'd30, v);
        checkRead(6'd30, v);
        // subu r31, r30, r26 then an immediate read of r31
        busWrite(`CORE_INST_ADDR, encodeOp(1, 5'd30, 5'd26, 5'd31, 16'h0000));
        model[31] = v - model[26];
        checkRead(6'd31, model[31]);
    endtask

    initial begin
        wait (cycleLimit != 0);
        repeat (cycleLimit) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rstN  = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        datIn = '0;
        $readmemh("sim/alu_patterns.txt", patMem);
        while (recordCount < MaxRecords &&
               patMem[4*recordCount] inside {32'd1, 32'd2, 32'd3}) begin
            recordCount++;
        end
        cycleLimit = recordCount * 40 + 2000;
        if (recordCount == 0) begin
            $display("No records could be read from the pattern file");
            totalErrors++;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        replayPatterns();
        runDependencyTest();
        reportTest(4);
        runReadAfterIssue();
        reportTest(6);

        $display("Summary: %0d checks, %0d errors", totalChecks, totalErrors);
        if (totalErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: wbAluCore.f
+incdir+include
logic/corePkg.sv
logic/instDecode.sv
logic/aluExecute.sv
logic/regResult.sv
logic/wbAluCore.sv
sim/wbAluCore_tb.sv

// File: Makefile
TOP = wbAluCore_tb
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f wbAluCore.f -o $(TOP)_sim

run: compile
	./obj_dir/$(TOP)_sim | tee $(LOG)
	grep -qx "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/alu_patterns.txt
// kind address data expected: 1 writes data to address, 2 reads address and expects a value
// 3 closes the test whose number is in data, 0 ends the list
1 00 3c017fff 00000000 // lui   r1, 0x7fff
1 00 3421ffff 00000000 // ori   r1, r1, 0xffff
2 01 00000000 7fffffff
1 00 24020001 00000000 // addiu r2, r0, 1
1 00 00221820 00000000 // add   r3, r1, r2
2 03 00000000 80000000
1 00 2404ffff 00000000 // addiu r4, r0, -1
1 00 00822821 00000000 // addu  r5, r4, r2
2 05 00000000 00000000
1 00 00443022 00000000 // sub   r6, r2, r4
2 06 00000000 00000002
1 00 00023823 00000000 // subu  r7, r0, r2
2 07 00000000 ffffffff
1 00 0082402a 00000000 // slt   r8, r4, r2
1 00 0044482b 00000000 // sltu  r9, r2, r4
2 08 00000000 00000001
2 09 00000000 00000001
3 00 00000001 00000000
1 00 200afffb 00000000 // addi  r10, r0, -5
2 0a 00000000 fffffffb
1 00 308b8001 00000000 // andi  r11, r4, 0x8001
2 0b 00000000 00008001
1 00 340c8000 00000000 // ori   r12, r0, 0x8000
2 0c 00000000 00008000
1 00 388d00ff 00000000 // xori  r13, r4, 0x00ff
2 0d 00000000 ffffff00
1 00 3c0ea5c3 00000000 // lui   r14, 0xa5c3
2 0e 00000000 a5c30000
1 00 002e7824 00000000 // and   r15, r1, r14
1 00 01cc8025 00000000 // or    r16, r14, r12
1 00 002e8826 00000000 // xor   r17, r1, r14
1 00 01cc9027 00000000 // nor   r18, r14, r12
2 0f 00000000 25c30000
2 10 00000000 a5c38000
2 11 00000000 da3cffff
2 12 00000000 5a3c7fff
3 00 00000002 00000000
1 00 24130024 00000000 // addiu r19, r0, 36
1 00 000ea100 00000000 // sll   r20, r14, 4
1 00 000eaa02 00000000 // srl   r21, r14, 8
1 00 000eb203 00000000 // sra   r22, r14, 8
1 00 026eb804 00000000 // sllv  r23, r14, r19
1 00 026ec006 00000000 // srlv  r24, r14, r19
1 00 026ec807 00000000 // srav  r25, r14, r19
2 14 00000000 5c300000
2 15 00000000 00a5c300
2 16 00000000 ffa5c300
2 17 00000000 5c300000
2 18 00000000 0a5c3000
2 19 00000000 fa5c3000
3 00 00000003 00000000
1 00 24001234 00000000 // addiu r0, r0, 0x1234
2 00 00000000 00000000
1 00 8c220000 00000000 // lw, not in the kept set
1 00 00000001 00000000 // SPECIAL with funct 0x01
1 00 70221020 00000000 // SPECIAL2 opcode
2 20 00000000 00000003
1 05 24030001 00000000 // addiu r3 to an address that does not issue
1 00 00000000 00000000 // nop
2 03 00000000 80000000
2 20 00000000 00000003
2 21 00000000 00000000
3 00 00000005 00000000
0 00 00000000 00000000
